/* dv/gidx_stimulus.txt */
# C <chunk hex, row 7 first, row 0 last>   X = clear pulse
# E <gid> <row> <hit> <slot> <first>, one record per output row in output order
C 79357353
E 3 0 0 0 1  E 3 2 0 0 0  E 3 5 0 0 0
E 5 1 0 1 1  E 5 4 0 1 0
E 7 3 0 2 1  E 7 7 0 2 0
E 9 6 0 3 1
C 535a3a55
E 5 0 1 1 1  E 5 1 1 1 0  E 5 5 1 1 0  E 5 7 1 1 0
E a 2 0 0 1  E a 4 0 0 0
E 3 3 0 1 1  E 3 6 0 1 0
X
C cc97c799
E 9 0 0 0 1  E 9 1 0 0 0  E 9 5 0 0 0
E 7 2 0 1 1  E 7 4 0 1 0
E c 3 0 2 1  E c 6 0 2 0  E c 7 0 2 0
C 65295c2c
E c 0 1 2 1  E c 2 1 2 0
E 2 1 0 3 1  E 2 5 0 3 0
E 5 3 0 0 1  E 5 6 0 0 0
E 9 4 0 1 1
E 6 7 0 2 1

/* dv/tb_gidx_scheduler.sv */
/*
 * Testbench for the group-index scheduler: stimulus file reader, chunk
 * driver, randomly stalled output checker, watchdog and closing report.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_gidx_scheduler;

  import gidx_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;

  logic      clk_i;
  logic      rst_ni;
  logic      clear_i;
  logic      gidx_valid_i;
  logic      out_ready_i;
  chunk_t    chunk_i;
  logic      gidx_ready_o;
  logic      out_valid_o;
  logic      hit_o;
  logic      first_o;
  gid_t      next_gidx_o;
  row_idx_t  next_row_o;
  slot_idx_t slot_o;

  // each operation in file order is a chunk or a clear.
  byte       op_kind[$];
  chunk_t    op_chunk[$];
  int        op_wait[$];    // rows that must be out before a clear.
  gid_t      exp_gid[$];
  row_idx_t  exp_row[$];
  logic      exp_hit[$];
  slot_idx_t exp_slot[$];
  logic      exp_first[$];

  int          checked      = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles       = 0;
  int          cycle_limit  = 0;
  int          num_chunks   = 0;
  logic [31:0] lcg_state    = 32'h2b75;

  gidx_scheduler_top #(
    .FIFO_DEPTH(4)
  ) gidx_scheduler_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .chunk_i     (chunk_i),
    .gidx_valid_i(gidx_valid_i),
    .out_ready_i (out_ready_i),
    .gidx_ready_o(gidx_ready_o),
    .out_valid_o (out_valid_o),
    .next_gidx_o (next_gidx_o),
    .next_row_o  (next_row_o),
    .hit_o       (hit_o),
    .slot_o      (slot_o),
    .first_o     (first_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // ##################################################
  // compare tasks.
  // ##################################################
  task automatic check_gid(input string name, input gid_t got, input gid_t exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%h, expected 0x%h (output %0d)", name, got, exp, checked);
      value_errors++;
    end
  endtask

  task automatic check_row(input string name, input row_idx_t got, input row_idx_t exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%h, expected 0x%h (output %0d)", name, got, exp, checked);
      value_errors++;
    end
  endtask

  task automatic check_slot(input string name, input slot_idx_t got, input slot_idx_t exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%h, expected 0x%h (output %0d)", name, got, exp, checked);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%h, expected 0x%h (output %0d)", name, got, exp, checked);
      value_errors++;
    end
  endtask

  task automatic compare_transfer();
    if (checked >= exp_gid.size()) begin
      $display("extra output row: gid 0x%h row %0d arrived after the last expected record",
               next_gidx_o, next_row_o);
      other_errors++;
    end else begin
      check_gid("next_gidx_o", next_gidx_o, exp_gid[checked]);
      check_row("next_row_o", next_row_o, exp_row[checked]);
      check_bit("hit_o", hit_o, exp_hit[checked]);
      check_slot("slot_o", slot_o, exp_slot[checked]);
      check_bit("first_o", first_o, exp_first[checked]);
      checked++;
    end
  endtask

  // ##################################################
  // stimulus file and chunk driver.
  // ##################################################
  task automatic read_stimulus();
    int          fd;
    int          c;
    int          code;
    int          g, r, h, s, f;
    logic [31:0] word;
    fd = $fopen("dv/gidx_stimulus.txt", "r");
    if (fd == 0) begin
      $display("stimulus file dv/gidx_stimulus.txt could not be opened");
      other_errors++;
      return;
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "C") begin
        code = $fscanf(fd, "%h", word);
        if (code != 1) begin
          $display("chunk record %0d in the stimulus file is malformed", num_chunks);
          other_errors++;
        end
        op_kind.push_back("C");
        op_chunk.push_back(chunk_t'(word));
        op_wait.push_back(0);
        num_chunks++;
      end else if (c == "X") begin
        op_kind.push_back("X");
        op_chunk.push_back('0);
        op_wait.push_back(exp_gid.size());
      end else if (c == "E") begin
        code = $fscanf(fd, "%h %h %h %h %h", g, r, h, s, f);
        if (code != 5) begin
          $display("expected-output record %0d in the stimulus file is malformed",
                   exp_gid.size());
          other_errors++;
        end
        exp_gid.push_back(gid_t'(g));
        exp_row.push_back(row_idx_t'(r));
        exp_hit.push_back(h[0]);
        exp_slot.push_back(slot_idx_t'(s));
        exp_first.push_back(f[0]);
      end else if (c == "#") begin
        while (c != -1 && c != 10) begin  // skip the comment line.
          c = $fgetc(fd);
        end
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // holds one chunk from a falling edge until the ready pulse is seen.
  task automatic drive_chunk(input chunk_t value);
    logic accepted;
    accepted     = 1'b0;
    chunk_i      = value;
    gidx_valid_i = 1'b1;
    while (!accepted) begin
      #1;
      accepted = gidx_ready_o;
      @(negedge clk_i);
    end
    gidx_valid_i = 1'b0;
  endtask

  task automatic report_counts();
    $display("rows checked %0d of %0d, value errors %0d, other errors %0d",
             checked, exp_gid.size(), value_errors, other_errors);
  endtask

  initial begin : stimulus_driver
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    gidx_valid_i = 1'b0;
    chunk_i      = '0;
    read_stimulus();
    cycle_limit = 40 * num_chunks + 200;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < op_kind.size(); i++) begin
      if (op_kind[i] == "C") begin
        drive_chunk(op_chunk[i]);
      end else begin
        while (checked < op_wait[i]) @(negedge clk_i);  // drain before the clear.
        clear_i = 1'b1;
        @(negedge clk_i);
        clear_i = 1'b0;
      end
    end
    while (checked < exp_gid.size()) @(negedge clk_i);
    repeat (20) @(negedge clk_i);
    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : output_checker
    out_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      lcg_state   = lcg_next(lcg_state);
      out_ready_i = (lcg_state[31:30] != 2'b00);  // high about 3 of 4 cycles.
      #1;
      if (rst_ni && out_valid_o && out_ready_i) begin
        compare_transfer();
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d expected rows never arrived",
               cycles, exp_gid.size() - checked);
      report_counts();
      $display("Test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
src/gidx_pkg.sv
src/gidx_lookahead.sv
src/gidx_entry_fifo.sv
src/gidx_row_order.sv
src/gidx_scheduler_top.sv
dv/tb_gidx_scheduler.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the scheduler testbench with Verilator and runs it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_gidx_scheduler -o sim_gidx
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/sim_gidx)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Test passed$" <<< "$sim_out"; then
  exit 0
fi
exit 1

/* src/gidx_entry_fifo.sv */
/*
 * Circular FIFO of lookahead entries with flush, full and empty flags.
 */
`timescale 1ns/10ps
`default_nettype none

module gidx_entry_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                flush_i,
  input  wire logic                push_i,
  input  wire gidx_pkg::la_entry_t  data_i,
  input  wire logic                pop_i,
  output logic                     full_o,
  output logic                     empty_o,
  output gidx_pkg::la_entry_t      data_o
);

  import gidx_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  la_entry_t            mem_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH):0] count_q;

  assign full_o  = (count_q == DEPTH);
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin : storage
    if (push_i && !full_o) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : pointers
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i && !full_o) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i && !empty_o) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (push_i && !full_o) - (pop_i && !empty_o);
    end
  end

  no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    !(push_i && full_o)) else $error("push into a full entry FIFO.");
  no_underflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    !(pop_i && empty_o)) else $error("pop from an empty entry FIFO.");

endmodule

`default_nettype wire

/* src/gidx_lookahead.sv */
/*
 * Lookahead stage: scans a held chunk one row per cycle, claims all rows
 * of each new gid, looks the gid up in the slot table and pushes one entry
 * per group. Misses take the round-robin replacement slot.
 */
`timescale 1ns/10ps
`default_nettype none

module gidx_lookahead (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               clear_i,
  input  wire gidx_pkg::chunk_t    chunk_i,
  input  wire logic               gidx_valid_i,
  input  wire logic               fifo_full_i,
  output logic                    gidx_ready_o,
  output logic                    fifo_push_o,
  output gidx_pkg::la_entry_t     fifo_entry_o
);

  import gidx_pkg::*;

  row_idx_t                  offset_q;
  row_mask_t                 claimed_q;
  row_mask_t                 claimed_next;
  row_mask_t                 group_mask;
  gid_t                      cur_gid;
  logic                      scan_en;
  logic                      new_group;
  logic                      chunk_done;

  logic [NUM_SLOTS-1:0]      slot_valid_q;
  gid_t [NUM_SLOTS-1:0]      slot_gid_q;
  slot_idx_t                 repl_ptr_q;
  slot_idx_t                 hit_slot;
  logic                      slot_hit;

  // ##################################################
  // row scan.
  // ##################################################
  assign scan_en   = gidx_valid_i && !fifo_full_i;
  assign cur_gid   = chunk_i[offset_q];
  assign new_group = !claimed_q[offset_q];  // first unclaimed row opens a group.

  always_comb begin : group_match
    for (int i = 0; i < NUM_ROWS; i++) begin
      group_mask[i] = (chunk_i[i] == cur_gid) && !claimed_q[i];
    end
  end

  assign claimed_next = claimed_q | group_mask;
  assign chunk_done   = (&claimed_next) || (offset_q == row_idx_t'(NUM_ROWS - 1));
  assign gidx_ready_o = scan_en && chunk_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin : scan_state
    if (!rst_ni) begin
      offset_q  <= '0;
      claimed_q <= '0;
    end else if (clear_i) begin
      offset_q  <= '0;
      claimed_q <= '0;
    end else if (scan_en) begin
      if (chunk_done) begin
        offset_q  <= '0;  // next chunk starts from row 0.
        claimed_q <= '0;
      end else begin
        offset_q  <= offset_q + 1'b1;
        claimed_q <= claimed_next;
      end
    end
  end

  // ##################################################
  // slot table with round-robin replacement.
  // ##################################################
  always_comb begin : slot_lookup
    slot_hit = 1'b0;
    hit_slot = '0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (slot_valid_q[s] && (slot_gid_q[s] == cur_gid) && !slot_hit) begin
        slot_hit = 1'b1;
        hit_slot = slot_idx_t'(s);
      end
    end
  end

  assign fifo_push_o = scan_en && new_group;

  always_ff @(posedge clk_i or negedge rst_ni) begin : slot_table
    if (!rst_ni) begin
      slot_valid_q <= '0;
      slot_gid_q   <= '0;
      repl_ptr_q   <= '0;
    end else if (clear_i) begin
      slot_valid_q <= '0;
      slot_gid_q   <= '0;
      repl_ptr_q   <= '0;
    end else if (fifo_push_o && !slot_hit) begin
      slot_valid_q[repl_ptr_q] <= 1'b1;
      slot_gid_q[repl_ptr_q]   <= cur_gid;
      if (repl_ptr_q == slot_idx_t'(NUM_SLOTS - 1)) begin
        repl_ptr_q <= '0;
      end else begin
        repl_ptr_q <= repl_ptr_q + 1'b1;
      end
    end
  end

  assign fifo_entry_o.gid  = cur_gid;
  assign fifo_entry_o.rows = group_mask;
  assign fifo_entry_o.hit  = slot_hit;
  assign fifo_entry_o.slot = slot_hit ? hit_slot : repl_ptr_q;  // a miss takes the victim slot.

  // the source must hold a chunk until the stage has accepted it.
  chunk_held_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    (gidx_valid_i && !gidx_ready_o) |=> (gidx_valid_i && $stable(chunk_i))
  ) else $error("chunk changed before the ready pulse.");

endmodule

`default_nettype wire

/* src/gidx_pkg.sv */
/*
 * Chunk geometry constants for the group-index scheduler, together with
 * the gid, row mask, row and slot index types and the lookahead entry.
 */
`default_nettype none

package gidx_pkg;

  // ##################################################
  // chunk geometry.
  // ##################################################
  localparam int unsigned NUM_ROWS       = 8;
  localparam int unsigned GID_WIDTH      = 4;
  localparam int unsigned NUM_SLOTS      = 4;
  localparam int unsigned ROW_IDX_WIDTH  = $clog2(NUM_ROWS);
  localparam int unsigned SLOT_IDX_WIDTH = $clog2(NUM_SLOTS);

  typedef logic [GID_WIDTH-1:0]                gid_t;
  typedef logic [NUM_ROWS-1:0][GID_WIDTH-1:0]  chunk_t;     // row 0 sits in the low bits.
  typedef logic [NUM_ROWS-1:0]                 row_mask_t;
  typedef logic [ROW_IDX_WIDTH-1:0]            row_idx_t;
  typedef logic [SLOT_IDX_WIDTH-1:0]           slot_idx_t;

  // one group of rows travelling from the lookahead to the ordering stage.
  typedef struct packed {
    gid_t      gid;
    row_mask_t rows;
    logic      hit;
    slot_idx_t slot;
  } la_entry_t;

endpackage

`default_nettype wire

/* src/gidx_row_order.sv */
/*
 * Ordering stage: emits the rows of the head entry in ascending order,
 * one per accepted cycle, and pops the entry with its last row.
 */
`timescale 1ns/10ps
`default_nettype none

module gidx_row_order (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                clear_i,
  input  wire gidx_pkg::la_entry_t  entry_i,
  input  wire logic                empty_i,
  input  wire logic                out_ready_i,
  output logic                     pop_o,
  output logic                     out_valid_o,
  output gidx_pkg::gid_t           next_gidx_o,
  output gidx_pkg::row_idx_t       next_row_o,
  output logic                     hit_o,
  output gidx_pkg::slot_idx_t      slot_o,
  output logic                     first_o
);

  import gidx_pkg::*;

  row_mask_t order_q;    // rows of the head entry not yet sent.
  row_mask_t remaining;
  row_mask_t row_bit;
  row_idx_t  row_ptr;
  logic      found;
  logic      first_q;
  logic      xfer;

  assign remaining = entry_i.rows & order_q;

  always_comb begin : lowest_row
    row_ptr = '0;
    found   = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (remaining[i] && !found) begin
        row_ptr = row_idx_t'(i);
        found   = 1'b1;
      end
    end
  end

  assign row_bit     = row_mask_t'(1) << row_ptr;
  assign out_valid_o = !empty_i;
  assign xfer        = out_valid_o && out_ready_i;
  assign pop_o       = xfer && ((remaining & ~row_bit) == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin : order_state
    if (!rst_ni) begin
      order_q <= '1;
      first_q <= 1'b1;
    end else if (clear_i || pop_o) begin
      order_q <= '1;
      first_q <= 1'b1;
    end else if (xfer) begin
      order_q <= order_q & ~row_bit;
      first_q <= 1'b0;
    end
  end

  assign next_gidx_o = entry_i.gid;
  assign next_row_o  = row_ptr;
  assign hit_o       = entry_i.hit;
  assign slot_o      = entry_i.slot;
  assign first_o     = first_q;

  rows_present_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    !empty_i |-> (found && (entry_i.rows != '0))) else $error("head entry has no rows.");

endmodule

`default_nettype wire

/* src/gidx_scheduler_top.sv */
/*
 * Group-index scheduler top: lookahead, entry FIFO and row ordering.
 */
`timescale 1ns/10ps
`default_nettype none

module gidx_scheduler_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              clear_i,
  input  wire gidx_pkg::chunk_t   chunk_i,
  input  wire logic              gidx_valid_i,
  input  wire logic              out_ready_i,
  output logic                   gidx_ready_o,
  output logic                   out_valid_o,
  output gidx_pkg::gid_t         next_gidx_o,
  output gidx_pkg::row_idx_t     next_row_o,
  output logic                   hit_o,
  output gidx_pkg::slot_idx_t    slot_o,
  output logic                   first_o
);

  import gidx_pkg::*;

  logic      fifo_push, fifo_pop;
  logic      fifo_full, fifo_empty;
  la_entry_t fifo_din, fifo_dout;

  gidx_lookahead gidx_lookahead_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .chunk_i     (chunk_i),
    .gidx_valid_i(gidx_valid_i),
    .fifo_full_i (fifo_full),
    .gidx_ready_o(gidx_ready_o),
    .fifo_push_o (fifo_push),
    .fifo_entry_o(fifo_din)
  );

  gidx_entry_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) gidx_entry_fifo_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(clear_i),
    .push_i (fifo_push),
    .data_i (fifo_din),
    .pop_i  (fifo_pop),
    .full_o (fifo_full),
    .empty_o(fifo_empty),
    .data_o (fifo_dout)
  );

  gidx_row_order gidx_row_order_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .entry_i    (fifo_dout),
    .empty_i    (fifo_empty),
    .out_ready_i(out_ready_i),
    .pop_o      (fifo_pop),
    .out_valid_o(out_valid_o),
    .next_gidx_o(next_gidx_o),
    .next_row_o (next_row_o),
    .hit_o      (hit_o),
    .slot_o     (slot_o),
    .first_o    (first_o)
  );

endmodule

`default_nettype wire
